// ==== csr_sys.f ====
+incdir+verilog
verilog/csr_sys_pkg.sv
verilog/stream_flow.sv
verilog/split_counter.sv
verilog/csr_read_unit.sv
verilog/csr_sys_top.sv
testbench/csr_sys_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the csr_sys testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

TOP=csr_sys_tb
LOG=sim.log

rm -f "$LOG"

verilator --binary -j 0 \
    --top-module "$TOP" \
    -f csr_sys.f \
    -o "$TOP" \
    > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/"$TOP" > "$LOG" 2>&1 \
    || echo "Simulator exited with a nonzero status"

grep -q "Test FAILED" "$LOG" && { echo "Simulation failed, see $LOG"; exit 1; }
grep -q "Test OK" "$LOG" || { echo "Simulation gave no result, see $LOG"; exit 1; }

echo "Simulation passed, see $LOG"
exit 0

// ==== testbench/csr_sys_patterns.txt ====
// Columns (hex): idle cycles, retire count per cycle, opcode, CSR number,
//   destination register, register status, res_ready stall (FF = random), result kind
// Result kind 1 expects one writeback, 0 expects the command to be consumed silently
// A line with idle FFFFFFFF ends the list

// Cycle and time reads right after reset
0 0 2 C00 01 1 0 1
3 0 2 C01 02 2 0 1
0 0 2 C00 03 3 0 1
0 0 2 C80 04 4 0 1
0 0 2 C81 05 5 0 1
0 0 1 C01 06 6 0 1
// Instret with small retire bursts
5 3 2 C02 07 1 0 1
0 1 2 C82 08 2 0 1
2 2 6 C02 09 3 0 1
// Retire counts near the 32-bit limit push the carry into the high word
4 FFFFFFF0 1 C02 0A 4 0 1
0 FFFFFFFF 2 C82 0B 5 0 1
2 FFFFFFFE 3 C82 0C 6 0 1
1 FFFFFFFF 2 C02 0D 7 0 1
0 0 5 C82 0E 0 0 1
3 0 7 C82 0F 1 0 1
// Destination x0, ENV and the reserved opcode 4 produce nothing
0 0 2 C00 00 2 0 0
0 0 2 C02 10 3 0 1
0 0 0 C00 11 4 0 0
0 0 2 C01 12 5 0 1
0 0 4 C02 13 6 0 0
0 0 5 C02 14 7 0 1
0 0 7 C82 00 1 0 0
0 0 6 C80 15 2 0 1
// Unknown CSR numbers under every CSR opcode
0 0 1 300 16 3 0 1
0 0 2 F14 17 4 0 1
0 0 3 C03 18 5 0 1
0 0 5 7C0 19 6 0 1
0 0 6 C83 1A 7 0 1
0 0 7 000 1B 0 0 1
0 0 3 B00 1C 1 0 1
// Back-pressure with commands waiting behind the held result
0 0 2 C00 1D 2 5 1
0 0 2 C02 1E 3 0 1
0 1 3 C80 1F 4 3 1
0 1 2 C01 01 5 0 1
0 0 0 C00 02 6 4 0
0 0 2 C00 03 7 0 1
2 2 6 C02 04 0 2 1
// Random stall lengths
0 1 2 C00 05 1 FF 1
0 0 2 C02 06 2 FF 1
0 3 7 C01 07 3 FF 1
1 0 5 C82 08 4 FF 1
0 0 2 C00 00 5 FF 0
0 2 1 C81 09 6 FF 1
// Idle stretches with retire activity
8 7 2 C02 0A 7 0 1
6 0 2 C00 0B 0 0 1
0 0 2 C80 0C 1 1 1
// End of list
FFFFFFFF 0 0 0 0 0 0 0

// ==== testbench/csr_sys_tb.sv ====
`timescale 1ns/1ps

module csr_sys_tb
    import csr_sys_pkg::*;
();

    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 16;
    localparam int          MAX_TESTS    = 64;
    localparam int          FIELDS       = 8;  // Columns per pattern line
    localparam int          ACCEPT_LIMIT = 64; // Cycles a command may wait for cmd_ready
    localparam int          DRAIN_LIMIT  = 64;
    localparam logic [31:0] RANDOM_STALL = 32'hFF;
    localparam logic [31:0] END_MARK     = 32'hFFFF_FFFF;

    logic          clk;
    logic          rst;
    retire_count_t retired_count;
    logic          cmd_valid;
    logic          cmd_ready;
    sys_op_t       cmd_op;
    csr_addr_t     cmd_csr;
    reg_addr_t     cmd_reg_addr;
    reg_status_t   cmd_reg_status;
    logic          res_valid;
    logic          res_ready;
    reg_addr_t     res_reg_addr;
    reg_status_t   res_reg_status;
    xlen_t         res_value;
    logic          res_speculative;

    logic [31:0] pat [MAX_TESTS*FIELDS];
    int          num_tests;
    int          budget_cycles = 0;
    logic [31:0] rng_state;

    // Counter sums through the previous edge and the one before it
    count_t cyc_d1;
    count_t cyc_d2;
    count_t ins_d1;
    count_t ins_d2;

    // Expected writebacks in issue order
    int          exp_test[$];
    reg_addr_t   exp_addr[$];
    reg_status_t exp_status[$];
    xlen_t       exp_value[$];

    int          stall_left;
    logic        cmd_taken;
    int          cur_test;
    logic        cur_kind;
    logic        result_due; // A writeback must show in the next cycle
    logic        held_valid; // Result was shown with res_ready low
    reg_addr_t   held_addr;
    reg_status_t held_status;
    xlen_t       held_value;
    int          hold_errs;
    int          pass_count;
    int          fail_count;
    int          other_errors;

    csr_sys_top dut0 (
        .clk             (clk),
        .rst             (rst),
        .retired_count   (retired_count),
        .cmd_valid       (cmd_valid),
        .cmd_ready       (cmd_ready),
        .cmd_op          (cmd_op),
        .cmd_csr         (cmd_csr),
        .cmd_reg_addr    (cmd_reg_addr),
        .cmd_reg_status  (cmd_reg_status),
        .res_valid       (res_valid),
        .res_ready       (res_ready),
        .res_reg_addr    (res_reg_addr),
        .res_reg_status  (res_reg_status),
        .res_value       (res_value),
        .res_speculative (res_speculative)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Counter word selected by a CSR number
    function automatic xlen_t expected_word(input logic [11:0] csr, input count_t cyc,
                                            input count_t ins);
        case (csr)
            CSR_CYCLE, CSR_TIME: return cyc[31:0]; // TIME reads the cycle counter
            CSR_CYCLEH, CSR_TIMEH: return cyc[63:32];
            CSR_INSTRET: return ins[31:0];
            CSR_INSTRETH: return ins[63:32];
            default: return '0;
        endcase
    endfunction

    task automatic check_result();
        int          t;
        int          errs;
        xlen_t       ev;
        reg_addr_t   ea;
        reg_status_t es;
        if (exp_test.size() == 0) begin
            $display("Unexpected result for x%0d with no command waiting for one", res_reg_addr);
            other_errors++;
            return;
        end
        t = exp_test.pop_front();
        ev = exp_value.pop_front();
        ea = exp_addr.pop_front();
        es = exp_status.pop_front();
        errs = hold_errs;
        hold_errs = 0;
        if (res_value !== ev) begin
            $display("[FAIL] test %0d res_value: got %h expected %h", t, res_value, ev);
            errs++;
        end
        if (res_reg_addr !== ea) begin
            $display("[FAIL] test %0d res_reg_addr: got %h expected %h", t, res_reg_addr, ea);
            errs++;
        end
        if (res_reg_status !== es) begin
            $display("[FAIL] test %0d res_reg_status: got %h expected %h", t, res_reg_status, es);
            errs++;
        end
        if (res_speculative !== 1'b0) begin
            $display("[FAIL] test %0d res_speculative: got %h expected 0", t, res_speculative);
            errs++;
        end
        if (errs == 0) begin
            $display("test %0d: x%0d = %h  PASS", t, ea, ev);
            pass_count++;
        end else begin
            $display("test %0d: %0d mismatches  FAIL", t, errs);
            fail_count++;
        end
    endtask

    // Outputs are stable here, between the falling edge and the next rising edge
    task automatic sample_outputs();
        if (held_valid) begin
            if (res_valid !== 1'b1) begin
                $display("Result was withdrawn while res_ready was low");
                hold_errs++;
            end else if (res_value !== held_value) begin
                $display("[FAIL] res_value under stall: was %h now %h", held_value, res_value);
                hold_errs++;
            end else if (res_reg_addr !== held_addr || res_reg_status !== held_status) begin
                $display("[FAIL] res_reg_addr/res_reg_status under stall: was %h/%h now %h/%h",
                         held_addr, held_status, res_reg_addr, res_reg_status);
                hold_errs++;
            end
        end
        if (res_valid && !res_ready && cmd_ready) begin
            $display("[FAIL] cmd_ready while result held: got %h expected %h", cmd_ready, 1'b0);
            hold_errs++;
        end
        if ((!res_valid || res_ready) && cmd_ready !== 1'b1) begin
            $display("[FAIL] cmd_ready with the result register free: got %h expected %h",
                     cmd_ready, 1'b1);
            other_errors++;
        end
        if (result_due && res_valid !== 1'b1) begin
            $display("A result was missing in the cycle after its command was accepted");
            other_errors++;
        end
        if (res_valid && res_ready) begin
            check_result();
        end
        result_due = 1'b0;
        if (cmd_valid && cmd_ready) begin
            cmd_taken = 1'b1;
            if (cur_kind) begin
                result_due = 1'b1;
                exp_test.push_back(cur_test);
                exp_addr.push_back(cmd_reg_addr);
                exp_status.push_back(cmd_reg_status);
                exp_value.push_back(expected_word(cmd_csr, cyc_d2, ins_d2));
            end
        end
        held_valid  = res_valid && !res_ready;
        held_addr   = res_reg_addr;
        held_status = res_reg_status;
        held_value  = res_value;
    endtask

    // A count taken at one edge shows on the counter output two edges later
    task automatic update_model();
        if (rst) begin
            cyc_d1 = '0;
            cyc_d2 = '0;
            ins_d1 = '0;
            ins_d2 = '0;
        end else begin
            cyc_d2 = cyc_d1;
            cyc_d1 = cyc_d1 + 64'd1;
            ins_d2 = ins_d1;
            ins_d1 = ins_d1 + 64'(retired_count);
        end
    endtask

    // One clock cycle, entered and left at a falling edge
    task automatic step();
        res_ready = (stall_left == 0);
        if (stall_left > 0) begin
            stall_left--;
        end
        #1;
        sample_outputs();
        @(posedge clk);
        update_model();
        @(negedge clk);
    endtask

    task automatic run_test(input int idx);
        logic [31:0] f_idle;
        logic [31:0] f_retire;
        logic [31:0] f_op;
        logic [31:0] f_csr;
        logic [31:0] f_rd;
        logic [31:0] f_status;
        logic [31:0] f_stall;
        logic [31:0] f_kind;
        int          stall;
        int          waited;
        f_idle   = pat[idx*FIELDS];
        f_retire = pat[idx*FIELDS + 1];
        f_op     = pat[idx*FIELDS + 2];
        f_csr    = pat[idx*FIELDS + 3];
        f_rd     = pat[idx*FIELDS + 4];
        f_status = pat[idx*FIELDS + 5];
        f_stall  = pat[idx*FIELDS + 6];
        f_kind   = pat[idx*FIELDS + 7];
        retired_count = f_retire;
        cmd_valid = 1'b0;
        repeat (f_idle) step();
        stall = int'(f_stall);
        if (f_stall == RANDOM_STALL) begin
            rng_state = xorshift32(rng_state);
            stall = 1 + int'(rng_state & 32'd7);
        end
        cmd_op         = sys_op_t'(f_op[2:0]);
        cmd_csr        = csr_addr_t'(f_csr[11:0]);
        cmd_reg_addr   = f_rd[4:0];
        cmd_reg_status = f_status[2:0];
        cur_test   = idx;
        cur_kind   = f_kind[0];
        cmd_valid  = 1'b1;
        stall_left = stall; // res_ready goes low from this cycle on
        cmd_taken  = 1'b0;
        waited     = 0;
        while (!cmd_taken && waited < ACCEPT_LIMIT) begin
            step();
            waited++;
        end
        cmd_valid = 1'b0;
        if (!cmd_taken) begin
            $display("test %0d: command was never accepted, cmd_ready stayed low", idx);
            fail_count++;
        end else if (!cur_kind) begin
            $display("test %0d: op %0d to x%0d taken with no result  PASS", idx, f_op, f_rd);
            pass_count++;
        end
    endtask

    initial begin
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the run finished", budget_cycles);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int idx;
        int sum;
        rst            = 1'b1;
        retired_count  = '0;
        cmd_valid      = 1'b0;
        cmd_op         = SYS_ENV;
        cmd_csr        = CSR_CYCLE;
        cmd_reg_addr   = '0;
        cmd_reg_status = '0;
        res_ready      = 1'b1;
        rng_state      = 32'hd14e_47fe;
        stall_left     = 0;
        cmd_taken      = 1'b0;
        cur_test       = 0;
        cur_kind       = 1'b0;
        result_due     = 1'b0;
        held_valid     = 1'b0;
        hold_errs      = 0;
        pass_count     = 0;
        fail_count     = 0;
        other_errors   = 0;
        update_model();
        $readmemh("testbench/csr_sys_patterns.txt", pat);
        num_tests = 0;
        sum = 0;
        while (num_tests < MAX_TESTS && pat[num_tests*FIELDS] !== END_MARK) begin
            sum += int'(pat[num_tests*FIELDS]) + 1;
            if (pat[num_tests*FIELDS + 6] == RANDOM_STALL) begin
                sum += 8;
            end else begin
                sum += int'(pat[num_tests*FIELDS + 6]);
            end
            num_tests++;
        end
        budget_cycles = RESET_CYCLES + 200 + 4 * sum;
        if (num_tests == 0) begin
            $display("No test patterns were read");
            other_errors++;
        end
        @(negedge clk);
        repeat (RESET_CYCLES) step();
        rst = 1'b0;
        if (res_valid !== 1'b0) begin
            $display("[FAIL] res_valid after reset: got %h expected %h", res_valid, 1'b0);
            other_errors++;
        end
        if (cmd_ready !== 1'b1) begin
            $display("[FAIL] cmd_ready after reset: got %h expected %h", cmd_ready, 1'b1);
            other_errors++;
        end
        for (idx = 0; idx < num_tests; idx++) begin
            run_test(idx);
        end
        idx = 0;
        while (exp_test.size() > 0 && idx < DRAIN_LIMIT) begin
            step();
            idx++;
        end
        if (exp_test.size() > 0) begin
            $display("%0d expected results never arrived", exp_test.size());
            fail_count += exp_test.size();
        end
        repeat (4) step(); // Catch any late extra result
        other_errors += hold_errs;
        $display("Tests passed: %0d  failed: %0d  other errors: %0d",
                 pass_count, fail_count, other_errors);
        if (fail_count == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/csr_read_unit.sv ====
`timescale 1ns/1ps

module csr_read_unit
    import csr_sys_pkg::*;
(
    input  logic        clk,
    input  logic        enable,

    // Command fields
    input  sys_op_t     op,
    input  csr_addr_t   csr,
    input  reg_addr_t   reg_addr,
    input  reg_status_t reg_status,

    // Live counter values
    input  count_t      cycle_count,
    input  count_t      instret_count,

    // Flow decisions
    output logic        consume,
    output logic        produce,

    // Registered writeback
    output reg_addr_t   res_reg_addr,
    output reg_status_t res_reg_status,
    output xlen_t       res_value,
    output logic        res_speculative
);

    localparam int WORD = $bits(xlen_t);

    xlen_t read_value; // Word selected by the CSR number
    logic  is_csr_op;  // Opcode reads a CSR
    logic  dest_nonzero;

    // TIME shares the cycle counter
    always_comb begin
        case (csr)
            CSR_CYCLE, CSR_TIME: begin
                read_value = cycle_count[WORD-1:0];
            end
            CSR_INSTRET: begin
                read_value = instret_count[WORD-1:0];
            end
            CSR_CYCLEH, CSR_TIMEH: begin
                read_value = cycle_count[2*WORD-1:WORD];
            end
            CSR_INSTRETH: begin
                read_value = instret_count[2*WORD-1:WORD];
            end
            default: begin
                read_value = '0; // Unimplemented CSRs read as zero
            end
        endcase
    end

    // All six CSR access forms read the counter before any write
    always_comb begin
        case (op)
            SYS_CSRRW, SYS_CSRRS, SYS_CSRRC: begin
                is_csr_op = 1'b1;
            end
            SYS_CSRRWI, SYS_CSRRSI, SYS_CSRRCI: begin
                is_csr_op = 1'b1; // Immediate forms read the same way
            end
            default: begin
                is_csr_op = 1'b0; // ENV and the reserved code
            end
        endcase
    end

    assign dest_nonzero = (reg_addr != '0);

    // Every command is taken; only real reads into x1..x31 write back
    assign consume = 1'b1;
    assign produce = is_csr_op && dest_nonzero;

    // Result holds until the next accepted command
    always_ff @(posedge clk) begin
        if (enable) begin
            res_reg_addr    <= reg_addr;
            res_reg_status  <= reg_status;
            res_value       <= read_value;
            res_speculative <= 1'b0; // Counter reads are never speculative
        end
    end

endmodule

// ==== verilog/csr_sys_defs.svh ====
`ifndef CSR_SYS_DEFS_SVH
`define CSR_SYS_DEFS_SVH

// Register writeback value width
`define CSR_SYS_XLEN 32

// Integer register file index
`define CSR_SYS_REG_ADDR_WIDTH 5

// Per-cycle retire count, wide enough to reach the instret carry quickly
`define CSR_SYS_RETIRE_WIDTH 32

// Scoreboard tag carried along with each destination register
`define CSR_SYS_STATUS_WIDTH 3

// Full machine counter width
`define CSR_SYS_COUNT_WIDTH 64

`endif

// ==== verilog/csr_sys_pkg.sv ====
`include "csr_sys_defs.svh"

package csr_sys_pkg;

    // funct3 field of a SYSTEM instruction
    typedef enum logic [2:0] {
        SYS_ENV    = 3'd0, // ECALL, EBREAK, xRET, WFI
        SYS_CSRRW  = 3'd1,
        SYS_CSRRS  = 3'd2,
        SYS_CSRRC  = 3'd3,
        SYS_CSRRWI = 3'd5, // Code 4 is reserved
        SYS_CSRRSI = 3'd6,
        SYS_CSRRCI = 3'd7
    } sys_op_t;

    // User-level counter CSR numbers
    typedef enum logic [11:0] {
        CSR_CYCLE    = 12'hC00,
        CSR_TIME     = 12'hC01,
        CSR_INSTRET  = 12'hC02,
        CSR_CYCLEH   = 12'hC80,
        CSR_TIMEH    = 12'hC81,
        CSR_INSTRETH = 12'hC82
    } csr_addr_t;

    // Destination register index
    typedef logic [`CSR_SYS_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Scoreboard tag, returned unchanged with the result
    typedef logic [`CSR_SYS_STATUS_WIDTH-1:0] reg_status_t;

    // Writeback value
    typedef logic [`CSR_SYS_XLEN-1:0] xlen_t;

    // Instructions retired in one cycle
    typedef logic [`CSR_SYS_RETIRE_WIDTH-1:0] retire_count_t;

    // Full 64-bit counter value
    typedef logic [`CSR_SYS_COUNT_WIDTH-1:0] count_t;

endpackage

// ==== verilog/csr_sys_top.sv ====
`timescale 1ns/1ps

module csr_sys_top
    import csr_sys_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    // Instructions retired this cycle
    input  retire_count_t retired_count,

    // Command stream
    input  logic          cmd_valid,
    output logic          cmd_ready,
    input  sys_op_t       cmd_op,
    input  csr_addr_t     cmd_csr,
    input  reg_addr_t     cmd_reg_addr,
    input  reg_status_t   cmd_reg_status,

    // Result stream
    output logic          res_valid,
    input  logic          res_ready,
    output reg_addr_t     res_reg_addr,
    output reg_status_t   res_reg_status,
    output xlen_t         res_value,
    output logic          res_speculative
);

    count_t cycle_count;   // Also serves TIME
    count_t instret_count;
    logic   consume;
    logic   produce;
    logic   enable;

    stream_flow u_flow (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (cmd_valid),
        .in_ready  (cmd_ready),
        .out_valid (res_valid),
        .out_ready (res_ready),
        .consume   (consume),
        .produce   (produce),
        .enable    (enable)
    );

    split_counter u_cycle_counter (
        .clk       (clk),
        .rst       (rst),
        .increment (retire_count_t'(1)), // One per clock
        .count     (cycle_count)
    );

    split_counter u_instret_counter (
        .clk       (clk),
        .rst       (rst),
        .increment (retired_count),
        .count     (instret_count)
    );

    csr_read_unit u_read (
        .clk             (clk),
        .enable          (enable),
        .op              (cmd_op),
        .csr             (cmd_csr),
        .reg_addr        (cmd_reg_addr),
        .reg_status      (cmd_reg_status),
        .cycle_count     (cycle_count),
        .instret_count   (instret_count),
        .consume         (consume),
        .produce         (produce),
        .res_reg_addr    (res_reg_addr),
        .res_reg_status  (res_reg_status),
        .res_value       (res_value),
        .res_speculative (res_speculative)
    );

endmodule

// ==== verilog/split_counter.sv ====
`timescale 1ns/1ps

module split_counter
    import csr_sys_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    input  retire_count_t increment, // Added every cycle after reset
    output count_t        count
);

    localparam int HALF_WIDTH = $bits(count_t) / 2;

    logic [HALF_WIDTH-1:0] partial; // Running low half, one cycle ahead
    logic                  carry;   // Carry out of the last low add
    logic [HALF_WIDTH:0]   low_sum;
    logic [HALF_WIDTH-1:0] count_lo;
    logic [HALF_WIDTH-1:0] count_hi;

    assign low_sum = (HALF_WIDTH + 1)'(partial) + (HALF_WIDTH + 1)'(increment);

    // First stage adds the low half and registers its carry. The second
    // stage passes the low half through and adds the carry to the high
    // half, so both halves line up two edges after the increment.
    always_ff @(posedge clk) begin
        if (rst) begin
            partial  <= '0;
            carry    <= 1'b0;
            count_lo <= '0;
            count_hi <= '0;
        end else begin
            {carry, partial} <= low_sum;
            count_lo <= partial;                         // Delay to match the high half
            count_hi <= count_hi + HALF_WIDTH'(carry);   // Short 32-bit chain only
        end
    end

    assign count = {count_hi, count_lo};

endmodule

// ==== verilog/stream_flow.sv ====
`timescale 1ns/1ps

module stream_flow (
    input  logic clk,
    input  logic rst,

    // Upstream command side
    input  logic in_valid,
    output logic in_ready,

    // Downstream result side
    output logic out_valid,
    input  logic out_ready,

    // Per-command decisions from the datapath
    input  logic consume,
    input  logic produce,

    // Advance the pipeline stage
    output logic enable
);

    logic out_free; // Output register empty or draining now

    // A held result blocks new commands until it is taken
    assign out_free = !out_valid || out_ready;

    // Commands are only taken when the datapath consumes them
    assign in_ready = consume && out_free;

    assign enable = in_valid && in_ready;

    // The output valid flag is the only state here. The payload lives
    // in the datapath and is loaded on enable.
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (enable) begin
            out_valid <= produce; // Consumed with no writeback leaves it empty
        end else if (out_ready) begin
            out_valid <= 1'b0; // Transfer done, nothing new behind it
        end
    end

endmodule
